// File: design/dds_pkg.sv
package dds_pkg;

   ////////////////////////////////////////////////////////////
   // signal path widths
   ////////////////////////////////////////////////////////////
   localparam int PHASE_W    = 32;
   localparam int LUT_ADDR_W = 10;                // phase top bits into the table
   localparam int LUT_DEPTH  = 2 ** LUT_ADDR_W;
   localparam int SAMPLE_W   = 12;
   localparam int SCOPE_W    = 8;
   localparam int WAVE_MAX   = 2 ** (SAMPLE_W - 1) - 1;   // 2047, full-scale amplitude
   localparam real PI        = 3.14159265358979323846;

   // lfsr and scope timing, scaled down for simulation
   localparam int LFSR_W            = 5;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'd1;
   localparam int LFSR_TICK_CYCLES  = 64;
   localparam int LFSR_CNT_W        = $clog2(LFSR_TICK_CYCLES);
   localparam int SCOPE_TICK_CYCLES = 7;
   localparam int SCOPE_CNT_W       = $clog2(SCOPE_TICK_CYCLES);
   localparam int SCOPE_CREDITS     = 4;              // consumer buffer depth
   localparam int CREDIT_W          = $clog2(SCOPE_CREDITS + 1);

   typedef logic [PHASE_W-1:0] phase_t;
   typedef logic signed [SAMPLE_W-1:0] wave_t;

   typedef struct packed {
      wave_t sin;
      wave_t cos;
      wave_t squ;
      wave_t saw;
   } wave_set_t;

   typedef enum logic [1:0] {sel_sin, sel_cos, sel_squ, sel_saw} wave_sel_e;
   typedef enum logic [1:0] {mod_ask, mod_bpsk, mod_none, mod_none2} mod_sel_e;

   typedef struct packed {
      logic [SCOPE_W-1:0] orig;   // offset binary
      logic [SCOPE_W-1:0] modd;
   } scope_sample_t;

   // one entry of the sine table, rounded to nearest
   function automatic wave_t sine_at(input int idx);
      real ang;
      real s;
      ang = 2.0 * PI * real'(idx) / real'(LUT_DEPTH);
      s   = real'(WAVE_MAX) * $sin(ang);
      if (s >= 0.0)
         return wave_t'($rtoi(s + 0.5));
      else
         return wave_t'($rtoi(s - 0.5));
   endfunction

endpackage

// File: design/kbd_pkg.sv
package kbd_pkg;

   ////////////////////////////////////////////////////////////
   // decoded key events, break code is make code with bit 7 set
   ////////////////////////////////////////////////////////////
   localparam logic [7:0] SC_MAKE_1      = 8'h16;
   localparam logic [7:0] SC_BREAK_1     = 8'h96;
   localparam logic [7:0] SC_MAKE_2      = 8'h1E;
   localparam logic [7:0] SC_BREAK_2     = 8'h9E;
   localparam logic [7:0] SC_MAKE_3      = 8'h26;
   localparam logic [7:0] SC_BREAK_3     = 8'hA6;
   localparam logic [7:0] SC_MAKE_4      = 8'h25;
   localparam logic [7:0] SC_BREAK_4     = 8'hA5;
   localparam logic [7:0] SC_MAKE_5      = 8'h2E;
   localparam logic [7:0] SC_BREAK_5     = 8'hAE;
   localparam logic [7:0] SC_MAKE_6      = 8'h36;
   localparam logic [7:0] SC_BREAK_6     = 8'hB6;
   localparam logic [7:0] SC_MAKE_7      = 8'h3D;
   localparam logic [7:0] SC_BREAK_7     = 8'hBD;
   localparam logic [7:0] SC_MAKE_8      = 8'h3E;
   localparam logic [7:0] SC_BREAK_8     = 8'hBE;
   localparam logic [7:0] SC_MAKE_F1     = 8'h05;
   localparam logic [7:0] SC_BREAK_F1    = 8'h85;
   localparam logic [7:0] SC_MAKE_F2     = 8'h06;
   localparam logic [7:0] SC_BREAK_F2    = 8'h86;
   localparam logic [7:0] SC_MAKE_N      = 8'h31;
   localparam logic [7:0] SC_BREAK_N     = 8'hB1;
   localparam logic [7:0] SC_MAKE_M      = 8'h3A;
   localparam logic [7:0] SC_BREAK_M     = 8'hBA;
   localparam logic [7:0] SC_MAKE_SPACE  = 8'h29;
   localparam logic [7:0] SC_BREAK_SPACE = 8'hA9;
   localparam logic [7:0] SC_MAKE_LEFT   = 8'h6B;   // extended codes, prefix dropped
   localparam logic [7:0] SC_BREAK_LEFT  = 8'hEB;
   localparam logic [7:0] SC_MAKE_RIGHT  = 8'h74;
   localparam logic [7:0] SC_BREAK_RIGHT = 8'hF4;
   localparam logic [7:0] SC_MAKE_UP     = 8'h75;
   localparam logic [7:0] SC_BREAK_UP    = 8'hF5;
   localparam logic [7:0] SC_MAKE_DOWN   = 8'h72;
   localparam logic [7:0] SC_BREAK_DOWN  = 8'hF2;

   typedef struct packed {
      logic       ready;
      logic [7:0] code;
   } key_event_t;

   typedef struct packed {
      logic k1, k2, k3, k4, k5, k6, k7, k8;
      logic f1, f2, n, m, space;
      logic left, right, up, down;
   } held_keys_t;

   localparam int NUM_KEYS = $bits(held_keys_t);

   // code tables in struct order, entry 0 is k1
   localparam logic [7:0] KEY_MAKE_CODES [NUM_KEYS] = '{
      SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
      SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
      SC_MAKE_SPACE, SC_MAKE_LEFT, SC_MAKE_RIGHT, SC_MAKE_UP, SC_MAKE_DOWN};
   localparam logic [7:0] KEY_BREAK_CODES [NUM_KEYS] = '{
      SC_BREAK_1, SC_BREAK_2, SC_BREAK_3, SC_BREAK_4, SC_BREAK_5, SC_BREAK_6,
      SC_BREAK_7, SC_BREAK_8, SC_BREAK_F1, SC_BREAK_F2, SC_BREAK_N, SC_BREAK_M,
      SC_BREAK_SPACE, SC_BREAK_LEFT, SC_BREAK_RIGHT, SC_BREAK_UP, SC_BREAK_DOWN};

endpackage

// File: design/key_hold_tracker.sv
`timescale 1ns/100ps

module key_hold_tracker
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  kbd_pkg::key_event_t key_event,
   output kbd_pkg::held_keys_t held_keys
);

   import kbd_pkg::*;

   logic [NUM_KEYS-1:0] held_q;   // msb is k1, same as the struct

   ////////////////////////////////////////////////////////////
   // make sets a flag, break clears it
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_q <= '0;
      end
      else if (key_event.ready)
      begin
         for (int k = 0; k < NUM_KEYS; k++)
         begin
            if (key_event.code == KEY_MAKE_CODES[k])
            begin
               held_q[NUM_KEYS-1-k] <= 1'b1;
            end
            else if (key_event.code == KEY_BREAK_CODES[k])
            begin
               held_q[NUM_KEYS-1-k] <= 1'b0;
            end
         end
      end
      // untracked codes fall through, flags hold
   end

   assign held_keys = held_keys_t'(held_q);

endmodule

// File: design/lfsr_tick.sv
`timescale 1ns/100ps

module lfsr_tick
(
   input  logic                        CLK_25MHZ,
   input  logic                        reset_from_key,
   output logic [dds_pkg::LFSR_W-1:0]  lfsr_value,
   output logic                        lfsr_bit
);

   import dds_pkg::*;

   logic [LFSR_CNT_W-1:0] tick_cnt;
   logic                  tick;
   logic [LFSR_W-1:0]     lfsr_q;

   ////////////////////////////////////////////////////////////
   // tick divider
   ////////////////////////////////////////////////////////////
   assign tick = (tick_cnt == LFSR_CNT_W'(LFSR_TICK_CYCLES - 1));   // wrap cycle

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt <= '0;
      end
      else if (tick)
      begin
         tick_cnt <= '0;
      end
      else
      begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // fibonacci lfsr, x^5 + x^3 + 1
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr_q <= LFSR_SEED;   // nonzero, so the all-zero lockup never happens
      end
      else if (tick)
      begin
         lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[4] ^ lfsr_q[2]};
      end
   end

   assign lfsr_value = lfsr_q;
   assign lfsr_bit   = lfsr_q[0];   // data bit for the keying

endmodule

// File: design/wave_gen.sv
`timescale 1ns/100ps

module wave_gen
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::phase_t    tune_word,
   output dds_pkg::wave_set_t waves
);

   import dds_pkg::*;

   phase_t                phase_q;
   logic [LUT_ADDR_W-1:0] sin_addr;
   logic [LUT_ADDR_W-1:0] cos_addr;
   wave_t                 sine_rom [LUT_DEPTH];
   wave_set_t             waves_q;

   ////////////////////////////////////////////////////////////
   // sine table, one full period
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < LUT_DEPTH; i++)
   begin : g_rom
      assign sine_rom[i] = sine_at(i);
   end

   ////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase_q <= '0;
      end
      else
      begin
         phase_q <= phase_q + tune_word;   // wraps mod 2^32
      end
   end

   assign sin_addr = phase_q[PHASE_W-1 -: LUT_ADDR_W];
   // quarter period ahead, wraps inside the table
   assign cos_addr = sin_addr + LUT_ADDR_W'(LUT_DEPTH / 4);

   ////////////////////////////////////////////////////////////
   // output registers, one cycle behind the accumulator
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         waves_q <= '0;
      end
      else
      begin
         waves_q.sin <= sine_rom[sin_addr];
         waves_q.cos <= sine_rom[cos_addr];
         if (phase_q[PHASE_W-1])
         begin
            waves_q.squ <= -wave_t'(WAVE_MAX);   // second half of the period
         end
         else
         begin
            waves_q.squ <= wave_t'(WAVE_MAX);
         end
         waves_q.saw <= wave_t'(phase_q[PHASE_W-1 -: SAMPLE_W]);   // ramp, signed
      end
   end

   assign waves = waves_q;

endmodule

// File: design/modulator.sv
`timescale 1ns/100ps

module modulator
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::wave_set_t waves,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::mod_sel_e  mod_sel,
   input  logic               lfsr_bit,
   output dds_pkg::wave_t     orig,
   output dds_pkg::wave_t     modd
);

   import dds_pkg::*;

   wave_t sel_wave;
   wave_t neg_wave;
   wave_t mod_wave;
   wave_t orig_q;
   wave_t modd_q;

   always_comb
   begin
      case (wave_sel)
         sel_sin: sel_wave = waves.sin;
         sel_cos: sel_wave = waves.cos;
         sel_squ: sel_wave = waves.squ;
         sel_saw: sel_wave = waves.saw;
      endcase
   end

   // -2048 has no positive twin, clip it
   assign neg_wave = (sel_wave == {1'b1, {(SAMPLE_W-1){1'b0}}}) ?
                     wave_t'(WAVE_MAX) : -sel_wave;

   always_comb
   begin
      case (mod_sel)
         mod_ask:             mod_wave = lfsr_bit ? sel_wave : '0;   // on/off keying
         mod_bpsk:            mod_wave = lfsr_bit ? sel_wave : neg_wave;
         mod_none, mod_none2: mod_wave = sel_wave;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         orig_q <= '0;
         modd_q <= '0;
      end
      else
      begin
         orig_q <= sel_wave;
         modd_q <= mod_wave;
      end
   end

   assign orig = orig_q;
   assign modd = modd_q;

endmodule

// File: design/scope_sampler.sv
`timescale 1ns/100ps

module scope_sampler
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  dds_pkg::wave_t         orig,
   input  dds_pkg::wave_t         modd,
   input  logic                   credit_return,
   output dds_pkg::scope_sample_t scope_sample,
   output logic                   scope_valid
);

   import dds_pkg::*;

   logic [SCOPE_CNT_W-1:0] strobe_cnt;
   logic                   strobe;
   logic                   take;
   logic [CREDIT_W-1:0]    credit_cnt;
   scope_sample_t          sample_q;
   logic                   valid_q;

   // flip the sign bit, keep the upper magnitude bits
   function automatic logic [SCOPE_W-1:0] to_offset(input wave_t w);
      return {~w[SAMPLE_W-1], w[SAMPLE_W-2 -: SCOPE_W-1]};
   endfunction

   ////////////////////////////////////////////////////////////
   // sample strobe
   ////////////////////////////////////////////////////////////
   assign strobe = (strobe_cnt == SCOPE_CNT_W'(SCOPE_TICK_CYCLES - 1));
   assign take   = strobe && (credit_cnt != '0);   // no credit, sample dropped

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         strobe_cnt <= '0;
         credit_cnt <= CREDIT_W'(SCOPE_CREDITS);
         valid_q    <= 1'b0;
      end
      else
      begin
         strobe_cnt <= strobe ? '0 : strobe_cnt + 1'b1;
         credit_cnt <= credit_cnt + CREDIT_W'(credit_return) - CREDIT_W'(take);
         valid_q    <= take;   // one cycle per accepted strobe
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (take)
      begin
         sample_q.orig <= to_offset(orig);
         sample_q.modd <= to_offset(modd);
      end
   end

   assign scope_sample = sample_q;
   assign scope_valid  = valid_q;

endmodule

// File: design/dds_lab_top.sv
`timescale 1ns/100ps

module dds_lab_top
(
   input  logic                        CLK_25MHZ,
   input  logic                        reset_from_key,
   input  kbd_pkg::key_event_t         key_event,
   input  dds_pkg::phase_t             tune_word,
   input  dds_pkg::wave_sel_e          wave_sel,
   input  dds_pkg::mod_sel_e           mod_sel,
   input  logic                        credit_return,
   output kbd_pkg::held_keys_t         held_keys,
   output logic [dds_pkg::LFSR_W-1:0]  lfsr_value,
   output dds_pkg::scope_sample_t      scope_sample,
   output logic                        scope_valid
);

   import dds_pkg::*;

   logic      lfsr_bit;
   wave_set_t waves;
   wave_t     orig;
   wave_t     modd;

   key_hold_tracker key_hold_tracker_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .held_keys      (held_keys)
   );

   lfsr_tick lfsr_tick_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_value     (lfsr_value),
      .lfsr_bit       (lfsr_bit)
   );

   wave_gen wave_gen_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tune_word      (tune_word),
      .waves          (waves)
   );

   modulator modulator_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .lfsr_bit       (lfsr_bit),
      .orig           (orig),
      .modd           (modd)
   );

   scope_sampler scope_sampler_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .orig           (orig),
      .modd           (modd),
      .credit_return  (credit_return),
      .scope_sample   (scope_sample),
      .scope_valid    (scope_valid)
   );

endmodule

// File: dv/dds_lab_model.svh
`ifndef DDS_LAB_MODEL_SVH
`define DDS_LAB_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model, stepped on every rising edge
////////////////////////////////////////////////////////////

// tracked keys in held_keys order, k1 first
localparam logic [7:0] MAKE_CODES [17] = '{
   SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
   SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
   SC_MAKE_SPACE, SC_MAKE_LEFT, SC_MAKE_RIGHT, SC_MAKE_UP, SC_MAKE_DOWN};
localparam logic [7:0] BREAK_CODES [17] = '{
   SC_BREAK_1, SC_BREAK_2, SC_BREAK_3, SC_BREAK_4, SC_BREAK_5, SC_BREAK_6,
   SC_BREAK_7, SC_BREAK_8, SC_BREAK_F1, SC_BREAK_F2, SC_BREAK_N, SC_BREAK_M,
   SC_BREAK_SPACE, SC_BREAK_LEFT, SC_BREAK_RIGHT, SC_BREAK_UP, SC_BREAK_DOWN};

logic [16:0]       m_held;      // bit 16 is k1
logic [LFSR_W-1:0] m_lfsr;
int                m_lfsr_cnt;
phase_t            m_phase;
wave_set_t         m_waves;
wave_t             m_orig;
wave_t             m_modd;
int                m_scnt;      // strobe counter
int                m_credits;
logic              m_valid;
scope_sample_t     m_sample;
wave_t             sine_tbl [1024];

// 2047 * sin(2 pi i / 1024), rounded to nearest
function automatic wave_t rounded_sine(input int i);
   real s;
   s = 2047.0 * $sin(2.0 * 3.14159265358979323846 * real'(i) / 1024.0);
   if (s >= 0.0)
      return wave_t'($rtoi(s + 0.5));
   else
      return wave_t'($rtoi(s - 0.5));
endfunction

// inverted sign, then bits 10 down to 4
function automatic logic [7:0] offset_code(input wave_t w);
   return {~w[11], w[10:4]};
endfunction

task automatic fill_sine_table();
   for (int i = 0; i < 1024; i++)
   begin
      sine_tbl[i] = rounded_sine(i);
   end
endtask

task automatic step_model();
   logic       strobe;
   logic       take;
   logic       lstep;
   logic [9:0] addr;
   wave_t      pick;
   if (reset_from_key)
   begin
      m_held     = '0;
      m_lfsr     = 5'd1;
      m_lfsr_cnt = 0;
      m_phase    = '0;
      m_waves    = '0;
      m_orig     = '0;
      m_modd     = '0;
      m_scnt     = 0;
      m_credits  = SCOPE_CREDITS;
      m_valid    = 1'b0;
   end
   else
   begin
      // scope sampler sees last cycle's modulator outputs
      strobe = (m_scnt == SCOPE_TICK_CYCLES - 1);
      take   = strobe && (m_credits != 0);
      if (take)
      begin
         m_sample.orig = offset_code(m_orig);
         m_sample.modd = offset_code(m_modd);
      end
      m_valid = take;
      m_scnt  = strobe ? 0 : m_scnt + 1;
      if (credit_return)
      begin
         m_credits++;
      end
      if (take)
      begin
         m_credits--;
      end
      case (wave_sel)
         sel_sin: pick = m_waves.sin;
         sel_cos: pick = m_waves.cos;
         sel_squ: pick = m_waves.squ;
         default: pick = m_waves.saw;
      endcase
      m_orig = pick;
      case (mod_sel)
         mod_ask:  m_modd = m_lfsr[0] ? pick : '0;
         mod_bpsk: m_modd = m_lfsr[0] ? pick : ((pick == 12'sh800) ? 12'sd2047 : -pick);
         default:  m_modd = pick;
      endcase
      // waveforms from the old accumulator value
      addr        = m_phase[31:22];
      m_waves.sin = sine_tbl[addr];
      m_waves.cos = sine_tbl[addr + 10'd256];
      m_waves.squ = m_phase[31] ? -12'sd2047 : 12'sd2047;
      m_waves.saw = wave_t'(m_phase[31:20]);
      m_phase     = m_phase + tune_word;
      lstep       = (m_lfsr_cnt == LFSR_TICK_CYCLES - 1);
      m_lfsr_cnt  = lstep ? 0 : m_lfsr_cnt + 1;
      if (lstep)
      begin
         m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
      end
      if (key_event.ready)
      begin
         for (int k = 0; k < 17; k++)
         begin
            if (key_event.code == MAKE_CODES[k])
               m_held[16-k] = 1'b1;
            else if (key_event.code == BREAK_CODES[k])
               m_held[16-k] = 1'b0;
         end
      end
   end
endtask

`endif

// File: dv/dds_lab_tb.sv
`timescale 1ns/100ps

module dds_lab_tb;

   import dds_pkg::*;
   import kbd_pkg::*;

   localparam int SEED       = 26787;
   localparam int WAIT_LIMIT = 400;   // cycles per wait for a sample
   localparam int KEY_EVENTS = 200;
   localparam int LFSR_STEPS = 40;

   logic              CLK_25MHZ;
   logic              reset_from_key;
   key_event_t        key_event;
   phase_t            tune_word;
   wave_sel_e         wave_sel;
   mod_sel_e          mod_sel;
   logic              credit_return;
   held_keys_t        held_keys;
   logic [LFSR_W-1:0] lfsr_value;
   scope_sample_t     scope_sample;
   logic              scope_valid;

   string test_name;
   int    err_count;
   int    err_base;
   int    pass_count;
   int    fail_count;
   bit    timeout_hit;
   bit    returns_on;     // consumer hands credits back
   int    owed;           // samples not yet returned
   int    valids_total;
   int    returned_total;

   `include "dds_lab_model.svh"

   dds_lab_top dds_lab_top_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .tune_word      (tune_word),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .credit_return  (credit_return),
      .held_keys      (held_keys),
      .lfsr_value     (lfsr_value),
      .scope_sample   (scope_sample),
      .scope_valid    (scope_valid)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz

   always @(posedge CLK_25MHZ) step_model();

   ////////////////////////////////////////////////////////////
   // reporting
   ////////////////////////////////////////////////////////////
   task automatic report_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_count++;
   endtask

   task automatic report_timeout(input string what);
      $display("timeout in %s: %s", test_name, what);
      timeout_hit = 1'b1;
      err_count++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_base  = err_count;
   endtask

   task automatic close_test();
      int errs;
      errs = err_count - err_base;
      if (errs == 0)
      begin
         pass_count++;
         $display("test %s: PASS", test_name);
      end
      else
      begin
         fail_count++;
         $display("test %s: FAIL with %0d errors", test_name, errs);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // one cycle, compare at the falling edge, then drive
   ////////////////////////////////////////////////////////////
   task automatic tick();
      @(negedge CLK_25MHZ);
      if (held_keys !== m_held)
         report_value("held_keys", 32'(m_held), 32'(held_keys));
      if (lfsr_value !== m_lfsr)
         report_value("lfsr_value", 32'(m_lfsr), 32'(lfsr_value));
      if (scope_valid !== m_valid)
         report_value("scope_valid", 32'(m_valid), 32'(scope_valid));
      if (m_valid && scope_sample !== m_sample)
         report_value("scope_sample", 32'(m_sample), 32'(scope_sample));
      if (scope_valid)
      begin
         owed++;
         valids_total++;
      end
      if (valids_total > SCOPE_CREDITS + returned_total)
      begin
         $display("[ERROR] %s more valid samples than credits granted", test_name);
         err_count++;
      end
      credit_return = 1'b0;
      if (returns_on && owed > 0 && $urandom % 2 == 0)
      begin
         credit_return = 1'b1;
         owed--;
         returned_total++;
      end
   endtask

   task automatic wait_valid();
      int n;
      n = 0;
      tick();
      while (!scope_valid && n < WAIT_LIMIT)
      begin
         tick();
         n++;
      end
      if (!scope_valid)
         report_timeout("no valid scope sample arrived");
   endtask

   task automatic collect_samples(input int count);
      for (int i = 0; i < count && !timeout_hit; i++)
      begin
         wait_valid();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////
   task automatic check_reset_state();
      start_test("reset_state");
      tick();
      if (scope_valid !== 1'b0)
         report_value("scope_valid", 32'd0, 32'(scope_valid));
      if (held_keys !== '0)
         report_value("held_keys", 32'd0, 32'(held_keys));
      if (lfsr_value !== 5'd1)
         report_value("lfsr_value", 32'd1, 32'(lfsr_value));
      close_test();
   endtask

   task automatic run_key_events();
      int kind;
      int k;
      start_test("held_keys");
      for (int i = 0; i < KEY_EVENTS; i++)
      begin
         tick();   // checks last cycle's event
         kind = $urandom % 4;
         k    = $urandom % 17;
         key_event.ready = (kind != 0);
         case (kind)
            1:       key_event.code = MAKE_CODES[k];
            2:       key_event.code = BREAK_CODES[k];
            default: key_event.code = 8'($urandom);   // mostly untracked
         endcase
      end
      tick();
      key_event.ready = 1'b0;
      tick();
      close_test();
   endtask

   task automatic follow_lfsr();
      logic [LFSR_W-1:0] seq [LFSR_STEPS];
      logic [LFSR_W-1:0] prev;
      int                n;
      start_test("lfsr_sequence");
      for (int s = 0; s < LFSR_STEPS && !timeout_hit; s++)
      begin
         prev = lfsr_value;
         n    = 0;
         tick();
         while (lfsr_value == prev && n < 2 * LFSR_TICK_CYCLES)
         begin
            tick();
            n++;
         end
         if (lfsr_value == prev)
            report_timeout("lfsr_value did not step");
         seq[s] = lfsr_value;
         if (lfsr_value == '0)
         begin
            $display("[ERROR] %s lfsr_value reached zero", test_name);
            err_count++;
         end
      end
      // a maximal-length lfsr repeats after 31 steps
      for (int s = 31; s < LFSR_STEPS && !timeout_hit; s++)
      begin
         if (seq[s] !== seq[s-31])
            report_value("lfsr repeat", 32'(seq[s-31]), 32'(seq[s]));
      end
      close_test();
   endtask

   task automatic sweep_waveforms();
      start_test("waveforms");
      returns_on = 1'b1;
      for (int w = 0; w < 4; w++)
      begin
         wave_sel  = wave_sel_e'(2'(w));
         mod_sel   = (w % 2 == 0) ? mod_none : mod_none2;   // both pass-through codes
         tune_word = $urandom;
         collect_samples(8);
      end
      close_test();
   endtask

   task automatic run_modulation();
      start_test("modulation");
      returns_on = 1'b1;
      for (int m = 0; m < 2; m++)
      begin
         mod_sel = (m == 0) ? mod_ask : mod_bpsk;
         for (int w = 0; w < 4; w++)
         begin
            wave_sel  = wave_sel_e'(2'(w));
            tune_word = $urandom >> 4;   // slower sweep
            collect_samples(10);
         end
      end
      close_test();
   endtask

   task automatic starve_credits();
      int seen;
      start_test("credits");
      returns_on = 1'b0;
      wave_sel   = sel_saw;
      mod_sel    = mod_bpsk;
      tune_word  = $urandom;
      seen       = 0;
      for (int i = 0; i < 20 * SCOPE_TICK_CYCLES; i++)
      begin
         tick();
         if (scope_valid)
            seen++;
      end
      if (seen > SCOPE_CREDITS)
         report_value("valids without returns", 32'(SCOPE_CREDITS), 32'(seen));
      returns_on = 1'b1;   // consumer drains again
      collect_samples(12);
      close_test();
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      void'($urandom(SEED));
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      key_event      = '0;
      tune_word      = '0;
      wave_sel       = sel_sin;
      mod_sel        = mod_none;
      credit_return  = 1'b0;
      err_count      = 0;
      pass_count     = 0;
      fail_count     = 0;
      timeout_hit    = 1'b0;
      returns_on     = 1'b0;
      owed           = 0;
      valids_total   = 0;
      returned_total = 0;
      fill_sine_table();
      repeat (4) @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;

      check_reset_state();
      if (!timeout_hit)
         run_key_events();
      if (!timeout_hit)
         follow_lfsr();
      if (!timeout_hit)
         sweep_waveforms();
      if (!timeout_hit)
         run_modulation();
      if (!timeout_hit)
         starve_credits();

      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               pass_count, fail_count, err_count);
      if (fail_count == 0 && err_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: dds_lab_top.f
+incdir+dv
design/dds_pkg.sv
design/kbd_pkg.sv
design/key_hold_tracker.sv
design/lfsr_tick.sv
design/wave_gen.sv
design/modulator.sv
design/scope_sampler.sv
design/dds_lab_top.sv
dv/dds_lab_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dds lab testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dds_lab_tb -f dds_lab_top.f -o dds_lab_sim \
   > build.log 2>&1 \
   && ./obj_dir/dds_lab_sim > sim.log 2>&1 \
   || { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation reported errors"; exit 1; }
exit 0
